/* files.f */
verilog/cache_test_pkg.sv
verilog/request_gen.sv
verilog/cache_ctrl.sv
verilog/main_memory.sv
verilog/cache_test_top.sv
sim/cache_test_tb.sv

/* sim/cache_test_tb.sv */
/*
  testbench for the cache exerciser
  runs the request pattern under several memory stall modes and checks every read response
*/
`timescale 1ns/1ps
`default_nettype none

module cache_test_tb;
  import cache_test_pkg::*;

  typedef enum logic [1:0] {
    stall_none,
    stall_third,
    stall_random
  } stall_mode_t;

  typedef struct packed {
    stall_mode_t mode;
    int          exp_hits;
    int          exp_misses;
  } row_t;

  localparam int num_rows     = 3;
  localparam int num_reads    = 2 * num_addresses;
  localparam int run_timeout  = 20000;
  localparam int quiet_cycles = 100;

  logic        clk;
  logic        rst;
  logic        mem_stall;
  logic        rsp_valid;
  cache_rsp_t  rsp;
  logic        done;

  stall_mode_t stall_mode;
  int          stall_phase;
  row_t        rows [num_rows];
  int          row_cycles [num_rows];
  int          errors;
  int          checks;
  int          seed_val;

  cache_test_top cache_test_top_inst (
    .clk       (clk),
    .rst       (rst),
    .mem_stall (mem_stall),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .done      (done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // stall pattern for the memory, chosen by the row under test
  always @(posedge clk) begin
    stall_phase <= (stall_phase == 2) ? 0 : stall_phase + 1;
    case (stall_mode)
      stall_third:  mem_stall <= (stall_phase == 2);
      stall_random: mem_stall <= $urandom % 2;
      default:      mem_stall <= 1'b0;
    endcase
  end

  // the n-th read goes to address number n/2 of the strided walk
  function automatic logic [data_width-1:0] expected_data(int n);
    int addr;
    addr = ((n / 2) * addr_stride) % (1 << addr_width);
    return data_width'(addr) ^ data_key;
  endfunction

  task automatic apply_reset();
    int i;
    @(posedge clk);
    rst <= 1'b1;
    for (i = 0; i < 4; i++) begin
      @(posedge clk);
    end
    rst <= 1'b0;
  endtask

  task automatic run_row(input int r, output logic timed_out);
    int cycles;
    int n_rsp;
    int hits;
    int misses;
    int i;
    cycles    = 0;
    n_rsp     = 0;
    hits      = 0;
    misses    = 0;
    timed_out = 1'b0;
    stall_mode = rows[r].mode;
    apply_reset();
    while ((n_rsp < num_reads) && !timed_out) begin
      @(negedge clk);
      cycles++;
      if (rsp_valid) begin
        checks += 3;
        if (cycles <= holdoff_cycles) begin
          $display("error at %0t ns: row %0d response in holdoff cycle %0d", $time, r, cycles);
          errors++;
        end
        if (rsp.data !== expected_data(n_rsp)) begin
          $display("error at %0t ns: row %0d read %0d data %h, expected %h",
                   $time, r, n_rsp, rsp.data, expected_data(n_rsp));
          errors++;
        end
        // first read of an address misses, the re-read hits
        if (rsp.hit !== logic'(n_rsp % 2)) begin
          $display("error at %0t ns: row %0d read %0d hit %b, expected %b",
                   $time, r, n_rsp, rsp.hit, n_rsp % 2);
          errors++;
        end
        if (rsp.hit === 1'b1) begin
          hits++;
        end else begin
          misses++;
        end
        n_rsp++;
      end
      if (cycles >= run_timeout) begin
        timed_out = 1'b1;
      end
    end
    if (timed_out) begin
      $display("row %0d stopped: only %0d of %0d read responses arrived within %0d cycles",
               r, n_rsp, num_reads, run_timeout);
      errors++;
    end else begin
      row_cycles[r] = cycles;
      checks += 3;
      if (done !== 1'b1) begin
        $display("error at %0t ns: row %0d done low after the last response", $time, r);
        errors++;
      end
      if ((hits != rows[r].exp_hits) || (misses != rows[r].exp_misses)) begin
        $display("error at %0t ns: row %0d counted %0d hits and %0d misses, expected %0d and %0d",
                 $time, r, hits, misses, rows[r].exp_hits, rows[r].exp_misses);
        errors++;
      end
      if ((r > 0) && (row_cycles[r] <= row_cycles[0])) begin
        $display("error at %0t ns: row %0d took %0d cycles, no longer than %0d without stall",
                 $time, r, row_cycles[r], row_cycles[0]);
        errors++;
      end
      for (i = 0; i < quiet_cycles; i++) begin
        @(negedge clk);
        checks++;
        if (rsp_valid) begin
          $display("error at %0t ns: row %0d extra response after the last read", $time, r);
          errors++;
        end
      end
    end
  endtask

  initial begin
    logic timed_out;
    int   r;
    rst         = 1'b1;
    mem_stall   = 1'b0;
    stall_mode  = stall_none;
    stall_phase = 0;
    errors      = 0;
    checks      = 0;
    seed_val    = $urandom(97);
    rows[0] = '{mode: stall_none,   exp_hits: num_addresses, exp_misses: num_addresses};
    rows[1] = '{mode: stall_third,  exp_hits: num_addresses, exp_misses: num_addresses};
    rows[2] = '{mode: stall_random, exp_hits: num_addresses, exp_misses: num_addresses};
    timed_out = 1'b0;
    for (r = 0; (r < num_rows) && !timed_out; r++) begin
      run_row(r, timed_out);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/cache_test_top.sv */
/*
  cache exerciser top level
  request generator, cache and main memory
*/
`timescale 1ns/1ps
`default_nettype none

module cache_test_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       mem_stall,
  output logic                       rsp_valid,
  output cache_test_pkg::cache_rsp_t rsp,
  output logic                       done
);
  import cache_test_pkg::*;

  logic                  req_valid;
  logic                  req_ready;
  cache_req_t            req;
  logic                  mem_start;
  mem_req_t              mem_req;
  logic                  mem_done;
  logic [data_width-1:0] mem_rdata;

  request_gen request_gen_inst (
    .clk       (clk),
    .rst       (rst),
    .req_ready (req_ready),
    .req_valid (req_valid),
    .req       (req),
    .done      (done)
  );

  cache_ctrl cache_ctrl_inst (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .mem_start (mem_start),
    .mem_req   (mem_req),
    .mem_done  (mem_done),
    .mem_rdata (mem_rdata)
  );

  main_memory main_memory_inst (
    .clk       (clk),
    .rst       (rst),
    .mem_start (mem_start),
    .mem_req   (mem_req),
    .mem_stall (mem_stall),
    .mem_done  (mem_done),
    .mem_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

/* verilog/main_memory.sv */
/*
  main memory model, word addressed, fixed access latency
  the latency count holds while mem_stall is high
*/
`timescale 1ns/1ps
`default_nettype none

module main_memory (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     mem_start,
  input  cache_test_pkg::mem_req_t mem_req,
  input  logic                     mem_stall,
  output logic                     mem_done,
  output logic [cache_test_pkg::data_width-1:0] mem_rdata
);
  import cache_test_pkg::*;

  logic [data_width-1:0] mem [mem_words];
  mem_req_t              req_q;
  logic                  busy;
  logic [3:0]            lat_cnt;
  logic                  finish;

  // the access completes in the last unstalled cycle of the count
  assign finish = busy && !mem_stall && (lat_cnt == 4'd1);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      lat_cnt  <= 4'd0;
      mem_done <= 1'b0;
    end else begin
      mem_done <= finish;
      if (mem_start) begin
        busy    <= 1'b1;
        lat_cnt <= 4'(mem_latency - 1);
      end else if (finish) begin
        busy <= 1'b0;
      end else if (busy && !mem_stall) begin
        lat_cnt <= lat_cnt - 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_start) begin
      req_q <= mem_req;
    end
    if (finish) begin
      if (req_q.op == op_write) begin
        mem[req_q.addr] <= req_q.wdata;
      end else begin
        mem_rdata <= mem[req_q.addr];
      end
    end
  end

  no_start_while_busy: assert property (@(posedge clk) disable iff (rst)
    mem_start |-> !busy);

endmodule

`default_nettype wire

/* verilog/cache_ctrl.sv */
/*
  direct-mapped write-through cache, one word per line, no write allocate
  one outstanding memory access at a time
*/
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req_valid,
  input  cache_test_pkg::cache_req_t req,
  output logic                       req_ready,
  output logic                       rsp_valid,
  output cache_test_pkg::cache_rsp_t rsp,
  output logic                       mem_start,
  output cache_test_pkg::mem_req_t   mem_req,
  input  logic                       mem_done,
  input  logic [cache_test_pkg::data_width-1:0] mem_rdata
);
  import cache_test_pkg::*;

  logic [num_lines-1:0]   valid_bits;
  logic [tag_width-1:0]   tag_mem  [num_lines];
  logic [data_width-1:0]  data_mem [num_lines];
  cache_state_t           state;
  cache_req_t             req_q;
  logic [index_width-1:0] idx;
  logic [tag_width-1:0]   tag;
  logic                   tag_hit;
  logic                   read_hit;
  logic [data_width-1:0]  rsp_data;
  logic                   rsp_hit;

  assign idx      = req_q.addr[index_width-1:0];
  assign tag      = req_q.addr[addr_width-1:index_width];
  assign tag_hit  = valid_bits[idx] && (tag_mem[idx] == tag);
  assign read_hit = tag_hit && (req_q.op == op_read);

  assign req_ready = (state == cs_idle);

  // everything except a read hit goes out to memory, writes always do
  assign mem_start = (state == cs_lookup) && !read_hit;
  assign mem_req   = '{op: req_q.op, addr: req_q.addr, wdata: req_q.wdata};

  assign rsp = '{data: rsp_data, hit: rsp_hit};

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= cs_idle;
      valid_bits <= '0;
      rsp_valid  <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      case (state)
        cs_idle: begin
          if (req_valid) begin
            state <= cs_lookup;
          end
        end
        cs_lookup: begin
          if (read_hit) begin
            state     <= cs_respond;
            rsp_valid <= 1'b1;
          end else begin
            state <= cs_mem_wait;
          end
        end
        cs_mem_wait: begin
          if (mem_done) begin
            if (req_q.op == op_read) begin
              valid_bits[idx] <= 1'b1;
              state           <= cs_respond;
              rsp_valid       <= 1'b1;
            end else begin
              state <= cs_idle;
            end
          end
        end
        cs_respond: begin
          state <= cs_idle;
        end
        default: begin
          state <= cs_idle;
        end
      endcase
    end
  end

  // line contents, the held request and the response payload
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      req_q <= req;
    end
    if (state == cs_lookup) begin
      if (read_hit) begin
        rsp_data <= data_mem[idx];
        rsp_hit  <= 1'b1;
      end else if (tag_hit) begin
        // write hit keeps the line in step with memory
        data_mem[idx] <= req_q.wdata;
      end
    end
    if ((state == cs_mem_wait) && mem_done && (req_q.op == op_read)) begin
      tag_mem[idx]  <= tag;
      data_mem[idx] <= mem_rdata;
      rsp_data      <= mem_rdata;
      rsp_hit       <= 1'b0;
    end
  end

  // the memory answers only while a miss or a write is outstanding
  mem_done_while_waiting: assert property (@(posedge clk) disable iff (rst)
    mem_done |-> (state == cs_mem_wait));

  // after a response the line holds the requested word
  rsp_line_holds_word: assert property (@(posedge clk) disable iff (rst)
    rsp_valid |-> valid_bits[idx] && (tag_mem[idx] == tag) && (data_mem[idx] == rsp.data));

endmodule

`default_nettype wire

/* verilog/request_gen.sv */
/*
  request generator
  waits out a holdoff after reset, then issues write, read, re-read per address
*/
`timescale 1ns/1ps
`default_nettype none

module request_gen (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req_ready,
  output logic                       req_valid,
  output cache_test_pkg::cache_req_t req,
  output logic                       done
);
  import cache_test_pkg::*;

  logic [7:0]            holdoff_cnt;
  logic                  holdoff_counting;
  logic [3:0]            dist_cnt;
  logic                  dist_reached;
  logic                  gen_step;
  logic                  accept;
  gen_state_t            state;
  gen_state_t            nxt_state;
  logic [addr_width-1:0] addr;
  logic [7:0]            req_cnt;

  assign holdoff_counting = (holdoff_cnt != 8'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      holdoff_cnt <= 8'(holdoff_cycles);
    end else if (holdoff_counting) begin
      holdoff_cnt <= holdoff_cnt - 8'd1;
    end
  end

  // counts ready cycles, a step is due once the count reaches distance
  assign dist_reached = (dist_cnt == 4'(distance));

  always_ff @(posedge clk) begin
    if (rst || holdoff_counting) begin
      dist_cnt <= 4'd0;
    end else if (req_ready) begin
      if (dist_reached) begin
        dist_cnt <= 4'd0;
      end else begin
        dist_cnt <= dist_cnt + 4'd1;
      end
    end
  end

  assign gen_step  = req_ready && dist_reached && !holdoff_counting && !done;
  assign req_valid = (state != gen_idle) && dist_reached && !holdoff_counting && !done;
  assign accept    = req_valid && req_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= gen_idle;
    end else if (gen_step) begin
      state <= nxt_state;
    end
  end

  always_comb begin
    case (state)
      gen_idle:   nxt_state = gen_write;
      gen_write:  nxt_state = gen_read;
      gen_read:   nxt_state = gen_reread;
      gen_reread: nxt_state = gen_write;
      default:    nxt_state = gen_idle;
    endcase
  end

  // the address moves on once its re-read has been taken
  always_ff @(posedge clk) begin
    if (rst) begin
      addr    <= '0;
      req_cnt <= 8'd0;
      done    <= 1'b0;
    end else if (accept) begin
      req_cnt <= req_cnt + 8'd1;
      if (state == gen_reread) begin
        addr <= addr + addr_width'(addr_stride);
      end
      if (req_cnt == 8'(num_requests - 1)) begin
        done <= 1'b1;
      end
    end
  end

  always_comb begin
    req.op    = (state == gen_write) ? op_write : op_read;
    req.addr  = addr;
    req.wdata = data_width'(addr) ^ data_key;
  end

  // no request may show up within holdoff_cycles cycles of the end of reset
  holdoff_quiet: assert property (@(posedge clk) disable iff (rst)
    req_valid |-> $past(!rst, holdoff_cycles));

endmodule

`default_nettype wire

/* verilog/cache_test_pkg.sv */
/*
  cache exerciser shared definitions
  sizes, request pattern timing, state and opcode enums, bus structs
*/
`default_nettype none

package cache_test_pkg;

  // address and data sizes
  localparam int addr_width  = 10;
  localparam int data_width  = 16;
  localparam int index_width = 4;
  localparam int tag_width   = addr_width - index_width;
  localparam int num_lines   = 1 << index_width;
  localparam int mem_words   = 1 << addr_width;

  // request pattern, distance must stay within 0 to 15
  localparam int holdoff_cycles = 80;
  localparam int distance       = 1;
  localparam int num_addresses  = 48;
  localparam int num_requests   = 3 * num_addresses;
  localparam int addr_stride    = 17;
  localparam logic [data_width-1:0] data_key = 16'ha5a5;

  // unstalled memory access time in cycles, the memory model needs at least 2
  localparam int mem_latency = 3;

  typedef enum logic [1:0] {
    gen_idle,
    gen_write,
    gen_read,
    gen_reread
  } gen_state_t;

  typedef enum logic {
    op_read,
    op_write
  } mem_op_t;

  typedef enum logic [1:0] {
    cs_idle,
    cs_lookup,
    cs_mem_wait,
    cs_respond
  } cache_state_t;

  typedef struct packed {
    mem_op_t               op;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
  } cache_req_t;

  typedef struct packed {
    mem_op_t               op;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [data_width-1:0] data;
    logic                  hit;
  } cache_rsp_t;

endpackage

`default_nettype wire
